/* Makefile */
TOOL       = verilator
FLAGS      = --binary -Wno-fatal -j 0
LINT_FLAGS = --lint-only -Wall
TOP        = tb_ooo_core
FILELIST   = filelist.f
BUILD      = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "TB PASSED"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

/* filelist.f */
rtl/ooo_pkg.sv
rtl/issue_decode.sv
rtl/reservation_station.sv
rtl/execute_units.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
tests/tb_ooo_core.sv

/* rtl/execute_units.sv */
module execute_units (
	input  logic              clock,
	input  logic              reset,
	// dispatch from reservation station
	input  logic              disp_valid,
	input  ooo_pkg::unit_e    disp_unit,
	input  ooo_pkg::opcode_e  disp_op,
	input  ooo_pkg::word_t    disp_a,
	input  ooo_pkg::word_t    disp_b,
	input  ooo_pkg::rob_tag_t disp_tag,
	output logic              alu_ready,
	// result bus
	output logic              cdb_valid,
	output ooo_pkg::rob_tag_t cdb_tag,
	output ooo_pkg::word_t    cdb_value
);
	import ooo_pkg::*;

	logic                    alu_fire;
	logic                    mul_fire;
	logic [$clog2(xlen)-1:0] shamt;
	word_t                   alu_result;

	// alu output register
	logic     alu_valid;
	rob_tag_t alu_tag;
	word_t    alu_value;

	// multiplier pipe, partial products then sum
	logic [mul_stages-1:0] mul_valid;
	rob_tag_t              mul_tag [mul_stages];
	word_t                 mul_lo;
	logic [xlen/2-1:0]     mul_hi;
	word_t                 mul_value [1:mul_stages-1];

	assign alu_fire = disp_valid & (disp_unit == unit_alu);
	assign mul_fire = disp_valid & (disp_unit == unit_mul);
	assign shamt    = disp_b[$clog2(xlen)-1:0];

	//////////////////////////////
	// alu
	//////////////////////////////

	always_comb begin
		case (disp_op)
			op_add, op_addi: alu_result = disp_a + disp_b;
			op_sub:          alu_result = disp_a - disp_b;
			op_and:          alu_result = disp_a & disp_b;
			op_or:           alu_result = disp_a | disp_b;
			op_xor:          alu_result = disp_a ^ disp_b;
			op_sll:          alu_result = disp_a << shamt;
			op_srl:          alu_result = disp_a >> shamt;
			default:         alu_result = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			alu_valid <= 1'b0;
		end else begin
			alu_valid <= alu_fire;
		end
	end

	always_ff @(posedge clock) begin
		alu_tag   <= disp_tag;
		alu_value <= alu_result;
	end

	//////////////////////////////
	// multiplier
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			mul_valid <= '0;
		end else begin
			mul_valid <= {mul_valid[mul_stages-2:0], mul_fire};
		end
	end

	// low half of the product only, upper cross term needs 16 bits
	always_ff @(posedge clock) begin
		mul_tag[0] <= disp_tag;
		mul_lo     <= disp_a * word_t'(disp_b[xlen/2-1:0]);
		mul_hi     <= disp_a[xlen/2-1:0] * disp_b[xlen-1:xlen/2];
		mul_value[1] <= mul_lo + {mul_hi, {(xlen/2){1'b0}}};
		for (int i = 1; i < mul_stages; i++) begin
			mul_tag[i] <= mul_tag[i-1];
		end
		for (int i = 2; i < mul_stages; i++) begin
			mul_value[i] <= mul_value[i-1];
		end
	end

	//////////////////////////////
	// result bus
	//////////////////////////////

	// a multiply lands next cycle, so hold alu dispatch
	assign alu_ready = ~mul_valid[mul_stages-2];

	assign cdb_valid = mul_valid[mul_stages-1] | alu_valid;
	assign cdb_tag   = mul_valid[mul_stages-1] ? mul_tag[mul_stages-1] : alu_tag;
	assign cdb_value = mul_valid[mul_stages-1] ? mul_value[mul_stages-1] : alu_value;

endmodule

/* rtl/issue_decode.sv */
module issue_decode (
	input  logic               clock,
	input  logic               reset,
	// apb slave
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  ooo_pkg::apb_addr_t paddr,
	input  ooo_pkg::word_t     pwdata,
	output ooo_pkg::word_t     prdata,
	output logic               pready,
	output logic               pslverr,
	// resource status
	input  logic               rob_full,
	input  logic               rs_full,
	input  ooo_pkg::rob_tag_t  alloc_tag,
	// rob read ports
	output ooo_pkg::rob_tag_t  rd1_tag,
	output ooo_pkg::rob_tag_t  rd2_tag,
	input  ooo_pkg::word_t     rd1_value,
	input  ooo_pkg::word_t     rd2_value,
	input  logic               rd1_done,
	input  logic               rd2_done,
	// commit from rob
	input  logic               commit_valid,
	input  logic               commit_wr_en,
	input  ooo_pkg::arch_reg_t commit_rd,
	input  ooo_pkg::word_t     commit_value,
	input  ooo_pkg::rob_tag_t  commit_tag,
	// issue
	output logic               issue_valid,
	output ooo_pkg::opcode_e   issue_op,
	output ooo_pkg::unit_e     issue_unit,
	output ooo_pkg::arch_reg_t issue_rd,
	output ooo_pkg::word_t     issue_imm,
	output ooo_pkg::word_t     src1_value,
	output ooo_pkg::word_t     src2_value,
	output ooo_pkg::rob_tag_t  src1_tag,
	output ooo_pkg::rob_tag_t  src2_tag,
	output logic               src1_ready,
	output logic               src2_ready
);
	import ooo_pkg::*;

	// committed registers and rename map
	word_t                regs [arch_regs];
	logic [arch_regs-1:0] map_valid;
	rob_tag_t             map_tag [arch_regs];

	logic       access;
	logic       is_issue;
	logic       is_read;
	logic       stall;
	arch_reg_t  reg_idx;
	logic [3:0] raw_op;
	arch_reg_t  rs1;
	arch_reg_t  rs2;

	//////////////////////////////
	// apb slave
	//////////////////////////////

	assign access  = psel & penable;
	// word aligned register window
	assign reg_idx = arch_reg_t'(paddr >> 2);
	assign is_issue = access & pwrite & (paddr == issue_offset);
	assign is_read  = access & ~pwrite &
		((paddr & ~apb_addr_t'(4 * (arch_regs - 1))) == reg_base_offset);

	// back-pressure only on issue writes
	assign stall       = rob_full | rs_full;
	assign pready      = access & ~(is_issue & stall);
	assign pslverr     = access & ~is_issue & ~is_read;
	assign prdata      = is_read ? regs[reg_idx] : '0;
	assign issue_valid = is_issue & ~stall;

	//////////////////////////////
	// decode
	//////////////////////////////

	assign raw_op     = pwdata[op_msb:op_lsb];
	assign issue_op   = (raw_op <= op_mul) ? opcode_e'(raw_op) : op_nop;
	assign issue_unit = (issue_op == op_mul) ? unit_mul : unit_alu;
	// nop never claims a destination
	assign issue_rd   = (issue_op == op_nop) ? '0 : pwdata[rd_msb:rd_lsb];
	assign issue_imm  = {{(xlen - (imm_msb - imm_lsb + 1)){pwdata[imm_msb]}},
		pwdata[imm_msb:imm_lsb]};
	assign rs1        = pwdata[rs1_msb:rs1_lsb];
	assign rs2        = pwdata[rs2_msb:rs2_lsb];

	// producer lookup in the rob
	assign rd1_tag = map_tag[rs1];
	assign rd2_tag = map_tag[rs2];

	// source 1 from regfile, rob value, or wait on tag
	always_comb begin
		src1_tag   = map_tag[rs1];
		src1_ready = 1'b1;
		src1_value = regs[rs1];
		if (map_valid[rs1]) begin
			src1_ready = rd1_done;
			src1_value = rd1_value;
		end
	end

	// source 2, addi always has its immediate
	always_comb begin
		src2_tag   = map_tag[rs2];
		src2_ready = 1'b1;
		src2_value = regs[rs2];
		if (map_valid[rs2] && issue_op != op_addi) begin
			src2_ready = rd2_done;
			src2_value = rd2_value;
		end
	end

	//////////////////////////////
	// map table and regfile
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			map_valid <= '0;
		end else begin
			// release only if no younger writer took the register
			if (commit_valid && commit_wr_en && map_tag[commit_rd] == commit_tag) begin
				map_valid[commit_rd] <= 1'b0;
			end
			// newest producer wins over same-cycle release
			if (issue_valid && issue_rd != '0) begin
				map_valid[issue_rd] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (issue_valid && issue_rd != '0) begin
			map_tag[issue_rd] <= alloc_tag;
		end
	end

	// architectural state, starts at zero
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < arch_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (commit_valid && commit_wr_en) begin
			regs[commit_rd] <= commit_value;
		end
	end

endmodule

/* rtl/ooo_core.sv */
module ooo_core (
	input  logic               clock,
	input  logic               reset,
	// apb slave
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  ooo_pkg::apb_addr_t paddr,
	input  ooo_pkg::word_t     pwdata,
	output ooo_pkg::word_t     prdata,
	output logic               pready,
	output logic               pslverr,
	// in-order commit stream
	output logic               commit_valid,
	output logic               commit_wr_en,
	output ooo_pkg::arch_reg_t commit_rd,
	output ooo_pkg::word_t     commit_value
);
	import ooo_pkg::*;

	// issue
	logic      issue_valid;
	opcode_e   issue_op;
	unit_e     issue_unit;
	arch_reg_t issue_rd;
	word_t     issue_imm;
	word_t     src1_value;
	word_t     src2_value;
	rob_tag_t  src1_tag;
	rob_tag_t  src2_tag;
	logic      src1_ready;
	logic      src2_ready;

	// rob
	logic     rob_full;
	rob_tag_t alloc_tag;
	rob_tag_t rd1_tag;
	rob_tag_t rd2_tag;
	word_t    rd1_value;
	word_t    rd2_value;
	logic     rd1_done;
	logic     rd2_done;
	rob_tag_t commit_tag;

	// dispatch
	logic     rs_full;
	logic     disp_valid;
	unit_e    disp_unit;
	opcode_e  disp_op;
	word_t    disp_a;
	word_t    disp_b;
	rob_tag_t disp_tag;

	// execute and result bus
	logic     alu_ready;
	logic     cdb_valid;
	rob_tag_t cdb_tag;
	word_t    cdb_value;

	//////////////////////////////
	// rename and issue
	//////////////////////////////

	issue_decode u_issue (
		.clock        (clock),
		.reset        (reset),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.rob_full     (rob_full),
		.rs_full      (rs_full),
		.alloc_tag    (alloc_tag),
		.rd1_tag      (rd1_tag),
		.rd2_tag      (rd2_tag),
		.rd1_value    (rd1_value),
		.rd2_value    (rd2_value),
		.rd1_done     (rd1_done),
		.rd2_done     (rd2_done),
		.commit_valid (commit_valid),
		.commit_wr_en (commit_wr_en),
		.commit_rd    (commit_rd),
		.commit_value (commit_value),
		.commit_tag   (commit_tag),
		.issue_valid  (issue_valid),
		.issue_op     (issue_op),
		.issue_unit   (issue_unit),
		.issue_rd     (issue_rd),
		.issue_imm    (issue_imm),
		.src1_value   (src1_value),
		.src2_value   (src2_value),
		.src1_tag     (src1_tag),
		.src2_tag     (src2_tag),
		.src1_ready   (src1_ready),
		.src2_ready   (src2_ready)
	);

	reservation_station u_rs (
		.clock      (clock),
		.reset      (reset),
		.issue_valid(issue_valid),
		.issue_op   (issue_op),
		.issue_unit (issue_unit),
		.issue_imm  (issue_imm),
		.src1_value (src1_value),
		.src2_value (src2_value),
		.src1_tag   (src1_tag),
		.src2_tag   (src2_tag),
		.src1_ready (src1_ready),
		.src2_ready (src2_ready),
		.issue_tag  (alloc_tag),
		.rs_full    (rs_full),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.cdb_value  (cdb_value),
		.alu_ready  (alu_ready),
		.disp_valid (disp_valid),
		.disp_unit  (disp_unit),
		.disp_op    (disp_op),
		.disp_a     (disp_a),
		.disp_b     (disp_b),
		.disp_tag   (disp_tag)
	);

	//////////////////////////////
	// execute and retire
	//////////////////////////////

	execute_units u_exec (
		.clock      (clock),
		.reset      (reset),
		.disp_valid (disp_valid),
		.disp_unit  (disp_unit),
		.disp_op    (disp_op),
		.disp_a     (disp_a),
		.disp_b     (disp_b),
		.disp_tag   (disp_tag),
		.alu_ready  (alu_ready),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.cdb_value  (cdb_value)
	);

	reorder_buffer u_rob (
		.clock        (clock),
		.reset        (reset),
		.issue_valid  (issue_valid),
		.issue_rd     (issue_rd),
		.issue_op     (issue_op),
		.rob_full     (rob_full),
		.alloc_tag    (alloc_tag),
		.rd1_tag      (rd1_tag),
		.rd2_tag      (rd2_tag),
		.rd1_value    (rd1_value),
		.rd2_value    (rd2_value),
		.rd1_done     (rd1_done),
		.rd2_done     (rd2_done),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_value    (cdb_value),
		.commit_valid (commit_valid),
		.commit_wr_en (commit_wr_en),
		.commit_rd    (commit_rd),
		.commit_value (commit_value),
		.commit_tag   (commit_tag)
	);

endmodule

/* rtl/ooo_pkg.sv */
package ooo_pkg;

	// datapath width
	localparam int xlen = 32;
	typedef logic [xlen-1:0] word_t;

	// architectural registers, r0 always reads zero
	localparam int arch_regs = 8;
	typedef logic [$clog2(arch_regs)-1:0] arch_reg_t;

	// reorder buffer, entry index doubles as rename tag
	localparam int rob_depth = 8;
	typedef logic [$clog2(rob_depth)-1:0] rob_tag_t;

	// shared reservation station pool
	localparam int rs_depth = 4;

	// dispatch to result bus
	localparam int mul_stages = 3;

	// opcodes, unlisted values decode as nop
	typedef enum logic [3:0] {
		op_nop  = 4'd0,
		op_add  = 4'd1,
		op_sub  = 4'd2,
		op_and  = 4'd3,
		op_or   = 4'd4,
		op_xor  = 4'd5,
		op_sll  = 4'd6,
		op_srl  = 4'd7,
		op_addi = 4'd8,
		op_mul  = 4'd9
	} opcode_e;

	// instruction word fields
	localparam int op_msb  = 31;
	localparam int op_lsb  = 28;
	localparam int rd_msb  = 27;
	localparam int rd_lsb  = 25;
	localparam int rs1_msb = 24;
	localparam int rs1_lsb = 22;
	localparam int rs2_msb = 21;
	localparam int rs2_lsb = 19;
	localparam int imm_msb = 15;
	localparam int imm_lsb = 0;

	// which unit executes an instruction
	typedef enum logic {
		unit_alu = 1'b0,
		unit_mul = 1'b1
	} unit_e;

	// apb register map
	typedef logic [7:0] apb_addr_t;
	localparam apb_addr_t issue_offset    = 8'h00;
	localparam apb_addr_t reg_base_offset = 8'h40;

endpackage

/* rtl/reorder_buffer.sv */
module reorder_buffer (
	input  logic               clock,
	input  logic               reset,
	// allocation
	input  logic               issue_valid,
	input  ooo_pkg::arch_reg_t issue_rd,
	input  ooo_pkg::opcode_e   issue_op,
	output logic               rob_full,
	output ooo_pkg::rob_tag_t  alloc_tag,
	// operand read ports
	input  ooo_pkg::rob_tag_t  rd1_tag,
	input  ooo_pkg::rob_tag_t  rd2_tag,
	output ooo_pkg::word_t     rd1_value,
	output ooo_pkg::word_t     rd2_value,
	output logic               rd1_done,
	output logic               rd2_done,
	// result bus
	input  logic               cdb_valid,
	input  ooo_pkg::rob_tag_t  cdb_tag,
	input  ooo_pkg::word_t     cdb_value,
	// commit
	output logic               commit_valid,
	output logic               commit_wr_en,
	output ooo_pkg::arch_reg_t commit_rd,
	output ooo_pkg::word_t     commit_value,
	output ooo_pkg::rob_tag_t  commit_tag
);
	import ooo_pkg::*;

	// entry payload
	logic [rob_depth-1:0] done;
	logic [rob_depth-1:0] wr_en;
	arch_reg_t            dest [rob_depth];
	word_t                value [rob_depth];

	// circular buffer pointers
	rob_tag_t                   head;
	rob_tag_t                   tail;
	logic [$clog2(rob_depth):0] count;

	logic rd1_hit;
	logic rd2_hit;

	// depth is a power of two, top count bit means full
	assign rob_full  = count[$clog2(rob_depth)];
	assign alloc_tag = tail;

	//////////////////////////////
	// read ports
	//////////////////////////////

	// result bus bypass for a tag finishing this cycle
	assign rd1_hit   = cdb_valid & (cdb_tag == rd1_tag);
	assign rd2_hit   = cdb_valid & (cdb_tag == rd2_tag);
	assign rd1_done  = done[rd1_tag] | rd1_hit;
	assign rd2_done  = done[rd2_tag] | rd2_hit;
	assign rd1_value = rd1_hit ? cdb_value : value[rd1_tag];
	assign rd2_value = rd2_hit ? cdb_value : value[rd2_tag];

	//////////////////////////////
	// commit
	//////////////////////////////

	assign commit_valid = (count != '0) & done[head];
	assign commit_wr_en = commit_valid & wr_en[head];
	assign commit_rd    = dest[head];
	assign commit_value = value[head];
	assign commit_tag   = head;

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (issue_valid) begin
				tail <= tail + 1;
			end
			if (commit_valid) begin
				head <= head + 1;
			end
			case ({issue_valid, commit_valid})
				2'b10:   count <= count + 1;
				2'b01:   count <= count - 1;
				default: count <= count;
			endcase
		end
	end

	// fill at tail, completion from the bus
	always_ff @(posedge clock) begin
		if (issue_valid) begin
			// nothing to execute for a nop
			done[tail]  <= (issue_op == op_nop);
			wr_en[tail] <= (issue_rd != '0) && (issue_op != op_nop);
			dest[tail]  <= issue_rd;
			value[tail] <= '0;
		end
		if (cdb_valid) begin
			done[cdb_tag]  <= 1'b1;
			value[cdb_tag] <= cdb_value;
		end
	end

endmodule

/* rtl/reservation_station.sv */
module reservation_station (
	input  logic              clock,
	input  logic              reset,
	// allocation
	input  logic              issue_valid,
	input  ooo_pkg::opcode_e  issue_op,
	input  ooo_pkg::unit_e    issue_unit,
	input  ooo_pkg::word_t    issue_imm,
	input  ooo_pkg::word_t    src1_value,
	input  ooo_pkg::word_t    src2_value,
	input  ooo_pkg::rob_tag_t src1_tag,
	input  ooo_pkg::rob_tag_t src2_tag,
	input  logic              src1_ready,
	input  logic              src2_ready,
	input  ooo_pkg::rob_tag_t issue_tag,
	output logic              rs_full,
	// result bus snoop
	input  logic              cdb_valid,
	input  ooo_pkg::rob_tag_t cdb_tag,
	input  ooo_pkg::word_t    cdb_value,
	// dispatch
	input  logic              alu_ready,
	output logic              disp_valid,
	output ooo_pkg::unit_e    disp_unit,
	output ooo_pkg::opcode_e  disp_op,
	output ooo_pkg::word_t    disp_a,
	output ooo_pkg::word_t    disp_b,
	output ooo_pkg::rob_tag_t disp_tag
);
	import ooo_pkg::*;

	logic [rs_depth-1:0] valid;
	logic [rs_depth-1:0] a_ready;
	logic [rs_depth-1:0] b_ready;
	logic [rs_depth-1:0] eligible;
	// per entry, mask of entries allocated before it
	logic [rs_depth-1:0] older [rs_depth];
	opcode_e             op [rs_depth];
	unit_e               unit [rs_depth];
	word_t               a_value [rs_depth];
	word_t               b_value [rs_depth];
	rob_tag_t            a_tag [rs_depth];
	rob_tag_t            b_tag [rs_depth];
	rob_tag_t            dst_tag [rs_depth];

	logic                        alloc_en;
	logic [$clog2(rs_depth)-1:0] alloc_idx;
	logic [$clog2(rs_depth)-1:0] disp_idx;

	// nops complete in the rob and never take a slot
	assign alloc_en = issue_valid & (issue_op != op_nop);
	assign rs_full  = &valid;

	// lowest free slot
	always_comb begin
		alloc_idx = '0;
		for (int i = rs_depth - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				alloc_idx = i[$clog2(rs_depth)-1:0];
			end
		end
	end

	// operands present and unit can accept
	always_comb begin
		for (int i = 0; i < rs_depth; i++) begin
			eligible[i] = valid[i] & a_ready[i] & b_ready[i] &
				((unit[i] == unit_mul) | alu_ready);
		end
	end

	// oldest eligible, nothing eligible is older than it
	always_comb begin
		disp_valid = 1'b0;
		disp_idx   = '0;
		for (int i = 0; i < rs_depth; i++) begin
			if (eligible[i] && (eligible & older[i]) == '0) begin
				disp_valid = 1'b1;
				disp_idx   = i[$clog2(rs_depth)-1:0];
			end
		end
	end

	assign disp_unit = unit[disp_idx];
	assign disp_op   = op[disp_idx];
	assign disp_a    = a_value[disp_idx];
	assign disp_b    = b_value[disp_idx];
	assign disp_tag  = dst_tag[disp_idx];

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else begin
			if (disp_valid) begin
				valid[disp_idx] <= 1'b0;
			end
			if (alloc_en) begin
				valid[alloc_idx] <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// operand capture and fill
	//////////////////////////////

	always_ff @(posedge clock) begin
		for (int i = 0; i < rs_depth; i++) begin
			if (cdb_valid && !a_ready[i] && a_tag[i] == cdb_tag) begin
				a_value[i] <= cdb_value;
				a_ready[i] <= 1'b1;
			end
			if (cdb_valid && !b_ready[i] && b_tag[i] == cdb_tag) begin
				b_value[i] <= cdb_value;
				b_ready[i] <= 1'b1;
			end
		end
		if (alloc_en) begin
			op[alloc_idx]      <= issue_op;
			unit[alloc_idx]    <= issue_unit;
			a_value[alloc_idx] <= src1_value;
			a_ready[alloc_idx] <= src1_ready;
			a_tag[alloc_idx]   <= src1_tag;
			// immediate replaces rs2 for addi
			b_value[alloc_idx] <= (issue_op == op_addi) ? issue_imm : src2_value;
			b_ready[alloc_idx] <= src2_ready;
			b_tag[alloc_idx]   <= src2_tag;
			dst_tag[alloc_idx] <= issue_tag;
			// new entry is younger than every live one
			for (int j = 0; j < rs_depth; j++) begin
				older[j][alloc_idx] <= 1'b0;
			end
			older[alloc_idx] <= valid;
		end
	end

endmodule

/* tests/ooo_trace.txt */
# name kind addr data rd value, all numbers hex
# write: expected commit rd and value; read: expected data in value; bad: rd 1 write, 0 read
alu_addi_r1 write 00 82000123 1 00000123
alu_addi_neg write 00 8400fffb 2 fffffffb
alu_addi_r3 write 00 86000004 3 00000004
alu_add write 00 18500000 4 0000011e
alu_sub write 00 2a500000 5 00000128
alu_and write 00 3c500000 6 00000123
alu_or write 00 4e580000 7 00000127
alu_xor write 00 58880000 4 fffffed8
alu_sll write 00 6a580000 5 00001230
alu_srl write 00 7c980000 6 0fffffff
nop_zero write 00 0e400000 0 00000000
nop_badop write 00 fe400000 0 00000000
dep_addi_1 write 00 82400001 1 00000124
dep_addi_2 write 00 82400001 1 00000125
dep_add write 00 14480000 2 0000024a
dep_sub write 00 26880000 3 00000125
dep_xor write 00 5ed00000 7 0000036f
ooo_mul write 00 98580000 4 00014f59
ooo_addi write 00 8a007fff 5 00007fff
ooo_mul_wide write 00 9cb00000 6 9ffffdb6
sll_shamt write 00 6b600000 5 fe000000
burst_seed write 00 86000003 3 00000003
burst_mul_01 write 00 9fd80000 7 00000a4d
burst_mul_02 write 00 9fd80000 7 00001ee7
burst_mul_03 write 00 9fd80000 7 00005cb5
burst_mul_04 write 00 9fd80000 7 0001161f
burst_mul_05 write 00 9fd80000 7 0003425d
burst_mul_06 write 00 9fd80000 7 0009c717
burst_mul_07 write 00 9fd80000 7 001d5545
burst_mul_08 write 00 9fd80000 7 0057ffcf
burst_mul_09 write 00 9fd80000 7 0107ff6d
burst_mul_10 write 00 9fd80000 7 0317fe47
r0_write write 00 10480000 0 0000024a
bad_write write_off bad 04 82000777 1 00000000

/* tests/tb_ooo_core.sv */
module tb_ooo_core;
	import ooo_pkg::*;

	// test names and kinds as packed text
	typedef logic [8*16-1:0] name_t;

	logic      clock;
	logic      reset;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	word_t     pwdata;
	word_t     prdata;
	logic      pready;
	logic      pslverr;
	logic      commit_valid;
	logic      commit_wr_en;
	arch_reg_t commit_rd;
	word_t     commit_value;

	// trace lines, in file order
	name_t     t_name [$];
	name_t     t_kind [$];
	apb_addr_t t_addr [$];
	word_t     t_data [$];
	arch_reg_t t_rd [$];
	word_t     t_value [$];

	// commits still owed, oldest first
	name_t     exp_name [$];
	arch_reg_t exp_rd [$];
	word_t     exp_value [$];

	// committed registers as the trace says they end up
	word_t     model_regs [arch_regs];

	integer seed;
	int     cycles;
	int     cycle_limit;

	ooo_core u_dut (
		.clock        (clock),
		.reset        (reset),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.commit_valid (commit_valid),
		.commit_wr_en (commit_wr_en),
		.commit_rd    (commit_rd),
		.commit_value (commit_value)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	//////////////////////////////
	// failure and compare
	//////////////////////////////

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run stopped at cycle %0d", cycles);
	endtask

	task automatic check_commit(input name_t name, input arch_reg_t want_rd,
		input word_t want_value, input logic want_wr_en, input arch_reg_t got_rd,
		input word_t got_value, input logic got_wr_en);
		if (got_rd !== want_rd || got_value !== want_value || got_wr_en !== want_wr_en) begin
			report_failure($sformatf(
				"mismatch %0s expected r%0d=%h wr_en %b actual r%0d=%h wr_en %b",
				name, want_rd, want_value, want_wr_en, got_rd, got_value, got_wr_en));
		end
	endtask

	task automatic check_read(input name_t name, input word_t want, input word_t got);
		if (got !== want) begin
			report_failure($sformatf("mismatch %0s expected %h actual %h", name, want, got));
		end
	endtask

	// pslverr and other single flags
	task automatic check_error(input name_t name, input logic want, input logic got);
		if (got !== want) begin
			report_failure($sformatf("mismatch %0s expected %b actual %b", name, want, got));
		end
	endtask

	//////////////////////////////
	// trace and apb driver
	//////////////////////////////

	function automatic logic is_kind(input name_t word);
		return word == "write" || word == "read" || word == "bad";
	endfunction

	task automatic load_trace(output int count);
		int               fd;
		int               code;
		name_t            tok;
		name_t            kind;
		apb_addr_t        addr;
		word_t            data;
		arch_reg_t        rd;
		word_t            value;
		logic [8*128-1:0] skip;
		count = 0;
		fd = $fopen("tests/ooo_trace.txt", "r");
		if (fd == 0) begin
			count = -1;
		end else begin
			code = $fscanf(fd, "%s", tok);
			while (code == 1) begin
				// a lone hash opens a column note
				if (tok == "#") begin
					code = $fgets(skip, fd);
				end else begin
					code = $fscanf(fd, "%s", kind);
					// a note word may stand between name and kind
					if (!is_kind(kind)) begin
						code = $fscanf(fd, "%s", kind);
					end
					code = $fscanf(fd, "%h %h %h %h", addr, data, rd, value);
					if (code != 4) begin
						report_failure($sformatf("trace line %0s is missing fields", tok));
					end
					t_name.push_back(tok);
					t_kind.push_back(kind);
					t_addr.push_back(addr);
					t_data.push_back(data);
					t_rd.push_back(rd);
					t_value.push_back(value);
					count++;
				end
				code = $fscanf(fd, "%s", tok);
			end
			$fclose(fd);
		end
	endtask

	// entered and left on a falling edge
	task automatic apb_transfer(input apb_addr_t addr, input logic write, input word_t data,
		output word_t rdata, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = data;
		@(negedge clock);
		penable = 1'b1;
		@(posedge clock);
		// held while the rob or rs is full
		while (!pready) begin
			@(posedge clock);
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge clock);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic idle_gap();
		int gap;
		gap = $unsigned($random(seed)) % 4;
		repeat (gap) @(negedge clock);
	endtask

	task automatic wait_drain();
		while (exp_name.size() != 0) begin
			@(negedge clock);
		end
	endtask

	//////////////////////////////
	// monitor and timeout
	//////////////////////////////

	always @(posedge clock) begin
		if (!reset && commit_valid) begin
			if (exp_name.size() == 0) begin
				report_failure($sformatf("commit to r%0d value %h arrived with nothing outstanding",
					commit_rd, commit_value));
			end else begin
				// r0 and nop commit without a register write
				check_commit(exp_name[0], exp_rd[0], exp_value[0], exp_rd[0] != '0,
					commit_rd, commit_value, commit_wr_en);
				void'(exp_name.pop_front());
				void'(exp_rd.pop_front());
				void'(exp_value.pop_front());
			end
		end
	end

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			report_failure($sformatf("timeout after %0d cycles with %0d commits outstanding",
				cycles, exp_name.size()));
		end
	end

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		word_t      rdata;
		logic       err;
		int         n_lines;
		name_t      rb_name;
		logic [7:0] digit;
		seed        = 32'hb921;
		cycles      = 0;
		cycle_limit = 0;
		reset       = 1'b1;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		for (int r = 0; r < arch_regs; r++) begin
			model_regs[r] = '0;
		end
		load_trace(n_lines);
		if (n_lines <= 0) begin
			report_failure("trace file tests/ooo_trace.txt is missing or holds no lines");
		end else begin
			cycle_limit = 40 * n_lines + 200;
			repeat (3) @(posedge clock);
			@(negedge clock);
			reset = 1'b0;
			check_error("reset_pready", 1'b0, pready);
			check_error("reset_pslverr", 1'b0, pslverr);
			check_error("reset_commit", 1'b0, commit_valid);
			for (int i = 0; i < n_lines; i++) begin
				idle_gap();
				if (t_kind[i] == "write") begin
					exp_name.push_back(t_name[i]);
					exp_rd.push_back(t_rd[i]);
					exp_value.push_back(t_value[i]);
					// r0 stays zero
					if (t_rd[i] != '0) begin
						model_regs[t_rd[i]] = t_value[i];
					end
					apb_transfer(t_addr[i], 1'b1, t_data[i], rdata, err);
					check_error(t_name[i], 1'b0, err);
				end else if (t_kind[i] == "read") begin
					// registers are architectural, so let the core go idle first
					wait_drain();
					apb_transfer(t_addr[i], 1'b0, '0, rdata, err);
					check_error(t_name[i], 1'b0, err);
					check_read(t_name[i], t_value[i], rdata);
				end else if (t_kind[i] == "bad") begin
					// rd column picks write or read
					apb_transfer(t_addr[i], t_rd[i][0], t_data[i], rdata, err);
					check_error(t_name[i], 1'b1, err);
				end else begin
					report_failure($sformatf("trace line %0s has an unknown kind %0s",
						t_name[i], t_kind[i]));
				end
			end
			wait_drain();
			// every register against the final committed state
			for (int r = 0; r < arch_regs; r++) begin
				digit   = 8'h30 + 8'(r);
				rb_name = {"readback_r", digit};
				idle_gap();
				apb_transfer(apb_addr_t'(reg_base_offset + 4 * r), 1'b0, '0, rdata, err);
				check_error(rb_name, 1'b0, err);
				check_read(rb_name, model_regs[r], rdata);
			end
			// catch stray commits after the last one
			repeat (4) @(negedge clock);
			if (exp_name.size() == 0) begin
				$display("TB PASSED");
				$finish;
			end else begin
				report_failure("commits still outstanding at end of trace");
			end
		end
	end

endmodule
